//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cache_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
+incdir+logic
logic/cache_pkg.sv
logic/cache_datapath.sv
logic/cache_controller.sv
logic/cache_top.sv
tb/tb_clock.sv
tb/mem_model.sv
tb/cache_tb.sv

//--- logic/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// word address, no byte offset
`define CACHE_ADDR_WIDTH 12

// one data word per line
`define CACHE_DATA_WIDTH 32

// 16 lines
`define CACHE_INDEX_WIDTH 4

// upper address bits kept as tag
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH)

`endif

//--- logic/cache_controller.sv
`default_nettype none

module cache_controller
    import cache_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,

    // processor strobes
    input  wire logic    cpu_req,
    input  wire logic    cpu_wr,
    input  wire logic    flush_req,
    output logic         cpu_done,
    output logic         flush_done,

    // datapath control
    output logic         wr_en,
    output cache_wr_sel_e wr_sel,
    output logic         flush_active,
    output logic         idx_clear,
    output logic         idx_inc,
    output logic         clear_valid,

    // datapath status
    input  wire logic    tag_match,
    input  wire logic    is_valid,
    input  wire logic    is_dirty,
    input  wire logic    flush_last,

    // AXI4-lite handshakes
    output logic         arvalid,
    input  wire logic    arready,
    input  wire logic    rvalid,
    output logic         rready,
    output logic         awvalid,
    input  wire logic    awready,
    output logic         wvalid,
    input  wire logic    wready,
    input  wire logic    bvalid,
    output logic         bready
);

    cache_state_e state;
    cache_state_e state_next;

    // set while the current operation is a flush
    logic op_flush;
    // AW and W handshakes seen so far in a write-back
    logic aw_done;
    logic w_done;
    logic wb_phase;
    logic wb_fin;

    assign wb_phase = (state == WB_ADDR) || (state == FLUSH_WB);

    // AW and W raised together, each dropped after its own handshake
    assign awvalid = wb_phase & ~aw_done;
    assign wvalid  = wb_phase & ~w_done;
    assign wb_fin  = (aw_done | awready) & (w_done | wready);

    assign arvalid = (state == FILL_ADDR);
    assign rready  = (state == FILL_DATA);
    assign bready  = (state == WB_RESP) || (state == FLUSH_RESP);

    assign flush_active = (state == FLUSH_CHECK) || (state == FLUSH_WB) ||
                          (state == FLUSH_RESP);

    assign cpu_done   = (state == DONE) & ~op_flush;
    assign flush_done = (state == DONE) & op_flush;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= IDLE;
            op_flush <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            state <= state_next;
            if (state == IDLE) begin
                op_flush <= flush_req;
            end
            if (wb_phase && wb_fin) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (awvalid && awready) begin
                    aw_done <= 1'b1;
                end
                if (wvalid && wready) begin
                    w_done <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        state_next  = state;
        wr_en       = 1'b0;
        wr_sel      = PROC_WRITE;
        idx_clear   = 1'b0;
        idx_inc     = 1'b0;
        clear_valid = 1'b0;

        unique case (state)
            IDLE: begin
                if (flush_req) begin
                    idx_clear  = 1'b1;
                    state_next = FLUSH_CHECK;
                end else if (cpu_req) begin
                    state_next = COMPARE;
                end
            end
            COMPARE: begin
                if (is_valid && tag_match) begin
                    wr_en      = cpu_wr;
                    state_next = DONE;
                end else if (is_valid && is_dirty) begin
                    state_next = WB_ADDR;
                end else if (cpu_wr) begin
                    // single-word line, a write miss just allocates
                    wr_en      = 1'b1;
                    state_next = DONE;
                end else begin
                    state_next = FILL_ADDR;
                end
            end
            WB_ADDR: begin
                if (wb_fin) begin
                    state_next = WB_RESP;
                end
            end
            WB_RESP: begin
                if (bvalid) begin
                    if (cpu_wr) begin
                        wr_en      = 1'b1;
                        state_next = DONE;
                    end else begin
                        state_next = FILL_ADDR;
                    end
                end
            end
            FILL_ADDR: begin
                if (arready) begin
                    state_next = FILL_DATA;
                end
            end
            FILL_DATA: begin
                if (rvalid) begin
                    wr_en      = 1'b1;
                    wr_sel     = MEMORY_WRITE;
                    state_next = DONE;
                end
            end
            FLUSH_CHECK: begin
                if (is_valid && is_dirty) begin
                    state_next = FLUSH_WB;
                end else begin
                    clear_valid = 1'b1;
                    idx_inc     = ~flush_last;
                    state_next  = flush_last ? DONE : FLUSH_CHECK;
                end
            end
            FLUSH_WB: begin
                if (wb_fin) begin
                    state_next = FLUSH_RESP;
                end
            end
            FLUSH_RESP: begin
                if (bvalid) begin
                    clear_valid = 1'b1;
                    idx_inc     = ~flush_last;
                    state_next  = flush_last ? DONE : FLUSH_CHECK;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/cache_datapath.sv
`default_nettype none

`include "cache_config.svh"

module cache_datapath
    import cache_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          reset,

    input  wire logic [`CACHE_ADDR_WIDTH-1:0]  cpu_addr,
    input  wire logic [`CACHE_DATA_WIDTH-1:0]  cpu_wdata,
    output logic      [`CACHE_DATA_WIDTH-1:0]  cpu_rdata,

    output logic      [`CACHE_ADDR_WIDTH-1:0]  araddr,
    input  wire logic [`CACHE_DATA_WIDTH-1:0]  rdata,
    output logic      [`CACHE_ADDR_WIDTH-1:0]  awaddr,
    output logic      [`CACHE_DATA_WIDTH-1:0]  wdata,

    input  wire logic                          wr_en,
    input  wire cache_wr_sel_e                 wr_sel,
    input  wire logic                          flush_active,
    input  wire logic                          idx_clear,
    input  wire logic                          idx_inc,
    input  wire logic                          clear_valid,

    output logic                               tag_match,
    output logic                               is_valid,
    output logic                               is_dirty,
    output logic                               flush_last
);

    localparam int NUM_LINES = 1 << `CACHE_INDEX_WIDTH;

    // line storage
    logic [`CACHE_DATA_WIDTH-1:0]  data_arr [NUM_LINES];
    logic [`CACHE_TAG_WIDTH-1:0]   tag_arr  [NUM_LINES];
    logic [NUM_LINES-1:0]          valid_bits;
    logic [NUM_LINES-1:0]          dirty_bits;

    logic [`CACHE_INDEX_WIDTH-1:0] flush_idx;
    logic [`CACHE_INDEX_WIDTH-1:0] index;
    logic [`CACHE_TAG_WIDTH-1:0]   cpu_tag;
    logic                          victim_sel;

    assign cpu_tag = cpu_addr[`CACHE_ADDR_WIDTH-1:`CACHE_INDEX_WIDTH];

    // flush walks the lines by counter, otherwise the address picks the line
    assign index = flush_active ? flush_idx : cpu_addr[`CACHE_INDEX_WIDTH-1:0];

    // lookup
    assign tag_match = (tag_arr[index] == cpu_tag);
    assign is_valid  = valid_bits[index];
    assign is_dirty  = dirty_bits[index];

    assign cpu_rdata = data_arr[index];

    // a flush only ever writes back the stored line
    assign victim_sel = flush_active | (is_valid & is_dirty & ~tag_match);

    assign araddr = cpu_addr;
    assign awaddr = victim_sel ? {tag_arr[index], index} : cpu_addr;
    assign wdata  = victim_sel ? data_arr[index] : cpu_wdata;

    // flush index counter
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flush_idx <= '0;
        end else if (idx_clear) begin
            flush_idx <= '0;
        end else if (idx_inc) begin
            flush_idx <= flush_idx + 1'b1;
        end
    end

    assign flush_last = (flush_idx == {`CACHE_INDEX_WIDTH{1'b1}});

    // data and tag of the selected line
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_sel == MEMORY_WRITE) begin
                data_arr[index] <= rdata;
            end else begin
                data_arr[index] <= cpu_wdata;
            end
            tag_arr[index] <= cpu_tag;
        end
    end

    // line state, processor writes leave the line dirty
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= (wr_sel == PROC_WRITE);
        end else if (clear_valid) begin
            valid_bits[index] <= 1'b0;
            dirty_bits[index] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // controller states
    typedef enum logic [3:0] {
        IDLE,
        // hit or miss decision
        COMPARE,
        // victim write-back, AW and W channels
        WB_ADDR,
        // wait for write response
        WB_RESP,
        // read miss, AR channel
        FILL_ADDR,
        // read miss, R channel
        FILL_DATA,
        // flush, look at the current line
        FLUSH_CHECK,
        // flush, write back a dirty line
        FLUSH_WB,
        FLUSH_RESP,
        // one-cycle completion pulse
        DONE
    } cache_state_e;

    // where a line write takes its data from
    typedef enum logic {
        // processor data, line becomes dirty
        PROC_WRITE,
        // memory read data, line stays clean
        MEMORY_WRITE
    } cache_wr_sel_e;

endpackage

`default_nettype wire

//--- logic/cache_top.sv
`default_nettype none

`include "cache_config.svh"

module cache_top
    import cache_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          reset,

    // processor port
    input  wire logic                          cpu_req,
    input  wire logic                          cpu_wr,
    input  wire logic [`CACHE_ADDR_WIDTH-1:0]  cpu_addr,
    input  wire logic [`CACHE_DATA_WIDTH-1:0]  cpu_wdata,
    input  wire logic                          flush_req,
    output logic      [`CACHE_DATA_WIDTH-1:0]  cpu_rdata,
    output logic                               cpu_done,
    output logic                               flush_done,

    // AXI4-lite master
    output logic      [`CACHE_ADDR_WIDTH-1:0]  araddr,
    output logic                               arvalid,
    input  wire logic                          arready,
    input  wire logic [`CACHE_DATA_WIDTH-1:0]  rdata,
    input  wire logic                          rvalid,
    output logic                               rready,
    output logic      [`CACHE_ADDR_WIDTH-1:0]  awaddr,
    output logic                               awvalid,
    input  wire logic                          awready,
    output logic      [`CACHE_DATA_WIDTH-1:0]  wdata,
    output logic                               wvalid,
    input  wire logic                          wready,
    input  wire logic                          bvalid,
    output logic                               bready
);

    // controller to datapath
    logic          wr_en;
    cache_wr_sel_e wr_sel;
    logic          flush_active;
    logic          idx_clear;
    logic          idx_inc;
    logic          clear_valid;

    // datapath to controller
    logic          tag_match;
    logic          is_valid;
    logic          is_dirty;
    logic          flush_last;

    cache_controller i_cache_controller (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_wr       (cpu_wr),
        .flush_req    (flush_req),
        .cpu_done     (cpu_done),
        .flush_done   (flush_done),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .flush_active (flush_active),
        .idx_clear    (idx_clear),
        .idx_inc      (idx_inc),
        .clear_valid  (clear_valid),
        .tag_match    (tag_match),
        .is_valid     (is_valid),
        .is_dirty     (is_dirty),
        .flush_last   (flush_last),
        .arvalid      (arvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rready       (rready),
        .awvalid      (awvalid),
        .awready      (awready),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    cache_datapath i_cache_datapath (
        .clk          (clk),
        .reset        (reset),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_rdata    (cpu_rdata),
        .araddr       (araddr),
        .rdata        (rdata),
        .awaddr       (awaddr),
        .wdata        (wdata),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .flush_active (flush_active),
        .idx_clear    (idx_clear),
        .idx_inc      (idx_inc),
        .clear_valid  (clear_valid),
        .tag_match    (tag_match),
        .is_valid     (is_valid),
        .is_dirty     (is_dirty),
        .flush_last   (flush_last)
    );

endmodule

`default_nettype wire

//--- tb/cache_tb.sv
`default_nettype none

`include "cache_config.svh"

module cache_tb;

    localparam int PERIOD    = 40;
    localparam int NUM_OPS   = 600;
    localparam int NUM_FLUSH = 4;
    localparam int NUM_LINES = 1 << `CACHE_INDEX_WIDTH;
    localparam int MEM_WORDS = 1 << `CACHE_ADDR_WIDTH;
    // a flush visits every line and may write each one back
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + NUM_FLUSH * NUM_LINES * 40 + 100;

    logic                          clk;
    logic                          reset;
    logic                          cpu_req;
    logic                          cpu_wr;
    logic [`CACHE_ADDR_WIDTH-1:0]  cpu_addr;
    logic [`CACHE_DATA_WIDTH-1:0]  cpu_wdata;
    logic                          flush_req;
    logic [`CACHE_DATA_WIDTH-1:0]  cpu_rdata;
    logic                          cpu_done;
    logic                          flush_done;
    logic [`CACHE_ADDR_WIDTH-1:0]  araddr;
    logic                          arvalid;
    logic                          arready;
    logic [`CACHE_DATA_WIDTH-1:0]  rdata;
    logic                          rvalid;
    logic                          rready;
    logic [`CACHE_ADDR_WIDTH-1:0]  awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [`CACHE_DATA_WIDTH-1:0]  wdata;
    logic                          wvalid;
    logic                          wready;
    logic                          bvalid;
    logic                          bready;

    // reference model of the cache lines
    logic [`CACHE_TAG_WIDTH-1:0]   m_tag   [NUM_LINES];
    logic [`CACHE_DATA_WIDTH-1:0]  m_data  [NUM_LINES];
    logic                          m_valid [NUM_LINES];
    logic                          m_dirty [NUM_LINES];
    // processor view and memory-side view
    logic [`CACHE_DATA_WIDTH-1:0]  shadow   [MEM_WORDS];
    logic [`CACHE_DATA_WIDTH-1:0]  mem_side [MEM_WORDS];

    // handshakes seen on the bus
    int ar_cnt = 0;
    int r_cnt  = 0;
    int aw_cnt = 0;
    int w_cnt  = 0;
    int b_cnt  = 0;
    logic [`CACHE_ADDR_WIDTH-1:0]  ar_addr_seen;
    logic [`CACHE_ADDR_WIDTH-1:0]  aw_addr_q [$];
    logic [`CACHE_DATA_WIDTH-1:0]  w_data_q  [$];
    // write-backs the model expects
    logic [`CACHE_ADDR_WIDTH-1:0]  exp_addr_q [$];
    logic [`CACHE_DATA_WIDTH-1:0]  exp_data_q [$];

    int     model_wbs    = 0;
    int     model_fills  = 0;
    int     value_errs   = 0;
    int     latency_errs = 0;
    int     traffic_errs = 0;
    integer seed = 32'hfd5;
    logic [31:0] rnd;
    logic [31:0] wdat;

    tb_clock #(.PERIOD(PERIOD)) i_tb_clock (.clk(clk));

    cache_top i_cache_top (
        .clk        (clk),
        .reset      (reset),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .flush_req  (flush_req),
        .cpu_rdata  (cpu_rdata),
        .cpu_done   (cpu_done),
        .flush_done (flush_done),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    mem_model #(.SEED(32'hfd5)) i_mem (
        .clk     (clk),
        .reset   (reset),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    // bus monitor
    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_cnt++;
            ar_addr_seen = araddr;
        end
        if (rvalid && rready) begin
            r_cnt++;
        end
        if (awvalid && awready) begin
            aw_cnt++;
            aw_addr_q.push_back(awaddr);
        end
        if (wvalid && wready) begin
            w_cnt++;
            w_data_q.push_back(wdata);
        end
        if (bvalid && bready) begin
            b_cnt++;
        end
    end

    // match observed write-backs against the expected victims in order
    task automatic compare_writebacks();
        logic [`CACHE_ADDR_WIDTH-1:0] got_addr;
        logic [`CACHE_DATA_WIDTH-1:0] got_data;
        logic [`CACHE_ADDR_WIDTH-1:0] exp_addr;
        logic [`CACHE_DATA_WIDTH-1:0] exp_data;
        if (aw_addr_q.size() != exp_addr_q.size() || w_data_q.size() != exp_addr_q.size()) begin
            traffic_errs++;
            $display("wrong write-back count at %0t: %0d AW and %0d W handshakes for %0d victims",
                     $time, aw_addr_q.size(), w_data_q.size(), exp_addr_q.size());
        end else begin
            while (exp_addr_q.size() > 0) begin
                got_addr = aw_addr_q.pop_front();
                got_data = w_data_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (got_addr != exp_addr || got_data != exp_data) begin
                    value_errs++;
                    $display("error at %0t: write-back %h:%h, expected %h:%h",
                             $time, got_addr, got_data, exp_addr, exp_data);
                end
            end
        end
        aw_addr_q.delete();
        w_data_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic access(input logic wr, input logic [`CACHE_ADDR_WIDTH-1:0] addr,
                          input logic [`CACHE_DATA_WIDTH-1:0] data);
        logic [`CACHE_INDEX_WIDTH-1:0] idx;
        logic [`CACHE_TAG_WIDTH-1:0]   tag;
        logic                          hit;
        logic [`CACHE_DATA_WIDTH-1:0]  got;
        int                            cycles;
        int                            ar_before;
        int                            r_before;
        int                            exp_fill;
        idx = addr[`CACHE_INDEX_WIDTH-1:0];
        tag = addr[`CACHE_ADDR_WIDTH-1:`CACHE_INDEX_WIDTH];
        hit = m_valid[idx] && (m_tag[idx] == tag);
        exp_fill = (!wr && !hit) ? 1 : 0;
        // dirty victim goes back to memory first
        if (!hit && m_valid[idx] && m_dirty[idx]) begin
            exp_addr_q.push_back({m_tag[idx], idx});
            exp_data_q.push_back(m_data[idx]);
            mem_side[{m_tag[idx], idx}] = m_data[idx];
            model_wbs++;
        end
        ar_before = ar_cnt;
        r_before  = r_cnt;

        @(negedge clk);
        cpu_req   = 1'b1;
        cpu_wr    = wr;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(negedge clk);
        cpu_req = 1'b0;
        cycles  = 1;
        while (!cpu_done) begin
            @(negedge clk);
            cycles++;
        end
        got = cpu_rdata;

        if (hit && cycles != 2) begin
            latency_errs++;
            $display("hit on %h finished after %0d cycles instead of 2", addr, cycles);
        end
        if (!wr && got != shadow[addr]) begin
            value_errs++;
            $display("error at %0t: read %h returned %h, expected %h",
                     $time, addr, got, shadow[addr]);
        end
        if (ar_cnt - ar_before != exp_fill || r_cnt - r_before != exp_fill) begin
            traffic_errs++;
            $display("%s of %h at %0t saw %0d AR and %0d R handshakes, expected %0d",
                     wr ? "write" : "read", addr, $time,
                     ar_cnt - ar_before, r_cnt - r_before, exp_fill);
        end else if (exp_fill == 1 && ar_addr_seen != addr) begin
            value_errs++;
            $display("error at %0t: fill of %h sent AR address %h",
                     $time, addr, ar_addr_seen);
        end
        compare_writebacks();

        if (wr) begin
            m_data[idx]  = data;
            m_dirty[idx] = 1'b1;
            shadow[addr] = data;
        end else if (!hit) begin
            m_data[idx]  = mem_side[addr];
            m_dirty[idx] = 1'b0;
            model_fills++;
        end
        m_tag[idx]   = tag;
        m_valid[idx] = 1'b1;
    endtask

    task automatic flush_all();
        logic [`CACHE_INDEX_WIDTH-1:0] li;
        logic [`CACHE_ADDR_WIDTH-1:0]  ad;
        int                            ar_before;
        ar_before = ar_cnt;
        // lines are walked from index 0 upward
        for (int i = 0; i < NUM_LINES; i++) begin
            li = i[`CACHE_INDEX_WIDTH-1:0];
            if (m_valid[li] && m_dirty[li]) begin
                exp_addr_q.push_back({m_tag[li], li});
                exp_data_q.push_back(m_data[li]);
                mem_side[{m_tag[li], li}] = m_data[li];
                model_wbs++;
            end
            m_valid[li] = 1'b0;
            m_dirty[li] = 1'b0;
        end

        @(negedge clk);
        flush_req = 1'b1;
        @(negedge clk);
        flush_req = 1'b0;
        while (!flush_done) begin
            @(negedge clk);
        end

        if (ar_cnt != ar_before) begin
            traffic_errs++;
            $display("flush at %0t issued %0d reads", $time, ar_cnt - ar_before);
        end
        compare_writebacks();
        // memory now holds everything the processor wrote
        for (int a = 0; a < MEM_WORDS; a++) begin
            ad = a[`CACHE_ADDR_WIDTH-1:0];
            if (i_mem.mem[ad] != shadow[ad]) begin
                value_errs++;
                $display("error at %0t: memory %h holds %h after flush, expected %h",
                         $time, ad, i_mem.mem[ad], shadow[ad]);
            end
        end
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b0;
        cpu_req   = 1'b0;
        cpu_wr    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        flush_req = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        // start from the memory's initial contents with all lines invalid
        for (int a = 0; a < MEM_WORDS; a++) begin
            shadow[a[`CACHE_ADDR_WIDTH-1:0]]   = i_mem.mem[a[`CACHE_ADDR_WIDTH-1:0]];
            mem_side[a[`CACHE_ADDR_WIDTH-1:0]] = i_mem.mem[a[`CACHE_ADDR_WIDTH-1:0]];
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            m_valid[i[`CACHE_INDEX_WIDTH-1:0]] = 1'b0;
            m_dirty[i[`CACHE_INDEX_WIDTH-1:0]] = 1'b0;
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            if (n > 0 && n % 150 == 0) begin
                flush_all();
            end
            rnd  = $random(seed);
            wdat = $random(seed);
            // four tags per index keep evictions frequent
            access(rnd[8], {6'b0, rnd[1:0], rnd[5:2]}, wdat);
        end
        flush_all();

        if (aw_cnt != model_wbs || w_cnt != model_wbs || b_cnt != model_wbs) begin
            traffic_errs++;
            $display("write-back handshakes lost or repeated: AW %0d W %0d B %0d, model %0d",
                     aw_cnt, w_cnt, b_cnt, model_wbs);
        end
        if (ar_cnt != model_fills || r_cnt != model_fills) begin
            traffic_errs++;
            $display("fill handshakes lost or repeated: AR %0d R %0d, model %0d",
                     ar_cnt, r_cnt, model_fills);
        end
        $display("summary: %0d ops, %0d value errors, %0d latency errors, %0d traffic errors",
                 NUM_OPS, value_errs, latency_errs, traffic_errs);
        if (value_errs + latency_errs + traffic_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/mem_model.sv
`default_nettype none

`include "cache_config.svh"

module mem_model #(
    parameter int SEED = 32'hfd5
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [`CACHE_ADDR_WIDTH-1:0]  araddr,
    input  wire logic                          arvalid,
    output logic                               arready,
    output logic      [`CACHE_DATA_WIDTH-1:0]  rdata,
    output logic                               rvalid,
    input  wire logic                          rready,
    input  wire logic [`CACHE_ADDR_WIDTH-1:0]  awaddr,
    input  wire logic                          awvalid,
    output logic                               awready,
    input  wire logic [`CACHE_DATA_WIDTH-1:0]  wdata,
    input  wire logic                          wvalid,
    output logic                               wready,
    output logic                               bvalid,
    input  wire logic                          bready
);

    localparam int MEM_WORDS = 1 << `CACHE_ADDR_WIDTH;

    logic [`CACHE_DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [`CACHE_ADDR_WIDTH-1:0] rd_addr;
    logic [`CACHE_ADDR_WIDTH-1:0] wr_addr;
    logic [`CACHE_DATA_WIDTH-1:0] wr_data;
    logic                         rd_busy;
    logic                         aw_got;
    logic                         w_got;
    // idle cycles before the next ready or valid, 0 to 3
    int                           ar_wait;
    int                           r_wait;
    int                           aw_wait;
    int                           w_wait;
    int                           b_wait;
    integer                       seed = SEED;

    // every address bit shows up in the word
    function automatic logic [`CACHE_DATA_WIDTH-1:0] init_word(
        input logic [`CACHE_ADDR_WIDTH-1:0] a
    );
        return {a, ~a[7:0], a ^ 12'h5a3};
    endfunction

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rd_addr <= '0;
            rd_busy <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            wr_addr <= '0;
            wr_data <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_wait <= 0;
            r_wait  <= 0;
            aw_wait <= 0;
            w_wait  <= 0;
            b_wait  <= 0;
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem[a[`CACHE_ADDR_WIDTH-1:0]] <= init_word(a[`CACHE_ADDR_WIDTH-1:0]);
            end
        end else begin
            // read address
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_addr <= araddr;
                rd_busy <= 1'b1;
            end else if (arvalid && !rd_busy) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            // read data
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
                ar_wait <= $random(seed) & 3;
                r_wait  <= $random(seed) & 3;
            end else if (rd_busy && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[rd_addr];
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
            // write address and data arrive independently
            if (awvalid && awready) begin
                awready <= 1'b0;
                wr_addr <= awaddr;
                aw_got  <= 1'b1;
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1;
                end
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                wr_data <= wdata;
                w_got   <= 1'b1;
            end else if (wvalid && !w_got) begin
                if (w_wait == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1;
                end
            end
            // response once both halves are in
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                aw_wait <= $random(seed) & 3;
                w_wait  <= $random(seed) & 3;
                b_wait  <= $random(seed) & 3;
            end else if (aw_got && w_got && !bvalid) begin
                if (b_wait == 0) begin
                    bvalid        <= 1'b1;
                    mem[wr_addr]  <= wr_data;
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire
